// ==== logic/rv_types_pkg.sv ====
package rv_types_pkg;

    typedef logic [31:0] word_t;        // register and bus data
    typedef logic [31:0] addr_t;        // byte address
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_sel_t;    // one bit per byte lane
    typedef logic [2:0]  funct3_t;

endpackage

// ==== logic/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef struct packed {
        logic arith_sub;
        logic shift_arith;
        logic res_cmp;
        logic res_bits;
        logic res_shift;
        logic bits_xor;
        logic bits_or;          // and when neither xor nor or
        logic cmp_lts;
        logic cmp_ltu;          // equality when neither lts nor ltu
        logic cmp_inv;
    } alu_ctrl_t;

    typedef struct packed {
        logic rs1;
        logic pc;
    } op1_src_t;

    typedef struct packed {
        logic rs2;
        logic imm_i;
        logic imm_u;
    } op2_src_t;

    typedef struct packed {
        logic alu;
        logic memory;
        logic pc_p4;
    } res_src_t;

    typedef struct packed {
        rv_types_pkg::reg_idx_t rs1;
        rv_types_pkg::reg_idx_t rs2;
        rv_types_pkg::reg_idx_t rd;
        rv_types_pkg::funct3_t  funct3;
        rv_types_pkg::word_t    imm;
        rv_types_pkg::addr_t    pc;
        op1_src_t               op1_src;
        op2_src_t               op2_src;
        alu_ctrl_t              alu_ctrl;
        res_src_t               res_src;
        logic                   reg_write;
        logic                   is_load;
        logic                   is_store;
        logic                   is_branch;
        logic                   is_jal;
        logic                   is_jalr;
    } decode_bus_t;

    typedef struct packed {
        rv_types_pkg::word_t    result;
        rv_types_pkg::word_t    store_data;
        rv_types_pkg::addr_t    pc_target;
        logic                   pc_select;
        rv_types_pkg::reg_idx_t rd;
        logic                   reg_write;
        res_src_t               res_src;
        rv_types_pkg::funct3_t  funct3;
        logic                   is_load;
        logic                   is_store;
        rv_types_pkg::addr_t    pc;
    } exec_bus_t;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WB
    } seq_state_t;

endpackage

// ==== logic/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch
#(
    parameter rv_types_pkg::addr_t RESET_ADDR = 32'h0000_0000
)
(
    input   logic                       i_clk,
    input   logic                       i_reset_n,
    input   logic                       i_fetch_ack,
    input   rv_types_pkg::word_t        i_instr,
    input   logic                       i_pc_load,
    input   logic                       i_pc_select,
    input   rv_types_pkg::addr_t        i_pc_target,
    output  rv_types_pkg::addr_t        o_pc,
    output  rv_types_pkg::word_t        o_instr
);

    rv_types_pkg::addr_t pc;
    rv_types_pkg::word_t instr;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= RESET_ADDR;
        else if (i_pc_load)
            pc <= i_pc_select ? i_pc_target : pc + 32'd4;   // taken jump or branch
    end

    always_ff @(posedge i_clk)
    begin
        if (i_fetch_ack)
            instr <= i_instr;   // held until the next fetch completes
    end

    assign o_pc    = pc;
    assign o_instr = instr;

endmodule

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
(
    input   rv_types_pkg::word_t        i_instr,
    input   rv_types_pkg::addr_t        i_pc,
    output  rv_ctrl_pkg::decode_bus_t   o_bus
);

    logic [6:0]             opcode;
    logic [6:0]             funct7;
    rv_types_pkg::funct3_t  funct3;
    rv_types_pkg::word_t    imm_i;
    rv_types_pkg::word_t    imm_s;
    rv_types_pkg::word_t    imm_b;
    rv_types_pkg::word_t    imm_u;
    rv_types_pkg::word_t    imm_j;

    // shared by OP and OP-IMM, only the register form may subtract
    function automatic rv_ctrl_pkg::alu_ctrl_t alu_decode(input rv_types_pkg::funct3_t f3,
                                                          input logic alt,
                                                          input logic reg_form);
        rv_ctrl_pkg::alu_ctrl_t ctrl;
        ctrl = '0;
        case (f3)
        3'b000: ctrl.arith_sub = alt & reg_form;
        3'b001, 3'b101:
        begin
            ctrl.res_shift   = 1'b1;
            ctrl.shift_arith = alt;
        end
        3'b010:
        begin
            ctrl.res_cmp = 1'b1;
            ctrl.cmp_lts = 1'b1;
        end
        3'b011:
        begin
            ctrl.res_cmp = 1'b1;
            ctrl.cmp_ltu = 1'b1;
        end
        3'b100:
        begin
            ctrl.res_bits = 1'b1;
            ctrl.bits_xor = 1'b1;
        end
        3'b110:
        begin
            ctrl.res_bits = 1'b1;
            ctrl.bits_or  = 1'b1;
        end
        default: ctrl.res_bits = 1'b1;
        endcase
        return ctrl;
    endfunction

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb
    begin
        o_bus            = '0;
        o_bus.rs1        = i_instr[19:15];
        o_bus.rs2        = i_instr[24:20];
        o_bus.rd         = i_instr[11:7];
        o_bus.funct3     = funct3;
        o_bus.pc         = i_pc;
        o_bus.op1_src    = '{rs1: 1'b1, pc: 1'b0};
        o_bus.op2_src    = '{rs2: 1'b1, imm_i: 1'b0, imm_u: 1'b0};
        o_bus.res_src    = '{alu: 1'b1, memory: 1'b0, pc_p4: 1'b0};
        case (opcode)
        rv_ctrl_pkg::OP_LUI:
        begin
            o_bus.rs1       = '0;   // x0 plus the upper immediate
            o_bus.imm       = imm_u;
            o_bus.op2_src   = '{rs2: 1'b0, imm_i: 1'b0, imm_u: 1'b1};
            o_bus.reg_write = 1'b1;
        end
        rv_ctrl_pkg::OP_AUIPC:
        begin
            o_bus.imm       = imm_u;
            o_bus.op1_src   = '{rs1: 1'b0, pc: 1'b1};
            o_bus.op2_src   = '{rs2: 1'b0, imm_i: 1'b0, imm_u: 1'b1};
            o_bus.reg_write = 1'b1;
        end
        rv_ctrl_pkg::OP_JAL:
        begin
            o_bus.imm       = imm_j;
            o_bus.is_jal    = 1'b1;
            o_bus.res_src   = '{alu: 1'b0, memory: 1'b0, pc_p4: 1'b1};
            o_bus.reg_write = 1'b1;
        end
        rv_ctrl_pkg::OP_JALR:
        begin
            o_bus.imm       = imm_i;
            o_bus.is_jalr   = 1'b1;
            o_bus.op2_src   = '{rs2: 1'b0, imm_i: 1'b1, imm_u: 1'b0};
            o_bus.res_src   = '{alu: 1'b0, memory: 1'b0, pc_p4: 1'b1};
            o_bus.reg_write = 1'b1;
        end
        rv_ctrl_pkg::OP_BRANCH:
        begin
            o_bus.imm              = imm_b;
            o_bus.is_branch        = 1'b1;
            o_bus.alu_ctrl.res_cmp = 1'b1;
            o_bus.alu_ctrl.cmp_lts = (funct3[2:1] == 2'b10);
            o_bus.alu_ctrl.cmp_ltu = (funct3[2:1] == 2'b11);
            o_bus.alu_ctrl.cmp_inv = funct3[0];     // bne, bge, bgeu
        end
        rv_ctrl_pkg::OP_LOAD:
        begin
            o_bus.imm       = imm_i;
            o_bus.is_load   = 1'b1;
            o_bus.op2_src   = '{rs2: 1'b0, imm_i: 1'b1, imm_u: 1'b0};
            o_bus.res_src   = '{alu: 1'b0, memory: 1'b1, pc_p4: 1'b0};
            o_bus.reg_write = 1'b1;
        end
        rv_ctrl_pkg::OP_STORE:
        begin
            o_bus.imm      = imm_s;
            o_bus.is_store = 1'b1;
            o_bus.op2_src  = '{rs2: 1'b0, imm_i: 1'b1, imm_u: 1'b0};
        end
        rv_ctrl_pkg::OP_IMM:
        begin
            o_bus.imm       = imm_i;
            o_bus.op2_src   = '{rs2: 1'b0, imm_i: 1'b1, imm_u: 1'b0};
            o_bus.alu_ctrl  = alu_decode(funct3, funct7[5], 1'b0);
            o_bus.reg_write = 1'b1;
        end
        rv_ctrl_pkg::OP_REG:
        begin
            o_bus.alu_ctrl  = alu_decode(funct3, funct7[5], 1'b1);
            o_bus.reg_write = 1'b1;
        end
        default: ;  // anything else runs as a no-op
        endcase
    end

endmodule

// ==== logic/rv_regs.sv ====
`timescale 1ns/1ps

module rv_regs
(
    input   logic                       i_clk,
    input   rv_types_pkg::reg_idx_t     i_rs1,
    input   rv_types_pkg::reg_idx_t     i_rs2,
    input   rv_types_pkg::reg_idx_t     i_rd,
    input   logic                       i_write,
    input   rv_types_pkg::word_t        i_data,
    output  rv_types_pkg::word_t        o_data1,
    output  rv_types_pkg::word_t        o_data2
);

    rv_types_pkg::word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge i_clk)
    begin
        if (i_write && (i_rd != '0))
            regs[i_rd] <= i_data;
    end

    assign o_data1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_data2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute
(
    input   logic                       i_clk,
    input   logic                       i_exec_en,
    input   rv_ctrl_pkg::decode_bus_t   i_bus,
    input   rv_types_pkg::word_t        i_rdata1,
    input   rv_types_pkg::word_t        i_rdata2,
    output  rv_ctrl_pkg::exec_bus_t     o_bus
);

    rv_types_pkg::word_t op1;
    rv_types_pkg::word_t op2;
    rv_types_pkg::word_t op_b;
    rv_types_pkg::word_t bits_res;
    rv_types_pkg::word_t shl_res;
    rv_types_pkg::word_t result;
    rv_types_pkg::addr_t target;
    logic [32:0]         sum;
    logic [32:0]         shr_res;
    logic                sub_en;
    logic                overflow;
    logic                eq;
    logic                lts;
    logic                ltu;
    logic                cmp_res;
    logic                take;

    always_comb
    begin
        case (1'b1)
        i_bus.op1_src.pc:  op1 = i_bus.pc;
        i_bus.op1_src.rs1: op1 = i_rdata1;
        default:           op1 = '0;
        endcase
    end

    always_comb
    begin
        case (1'b1)
        i_bus.op2_src.imm_i, i_bus.op2_src.imm_u: op2 = i_bus.imm;
        i_bus.op2_src.rs2:                        op2 = i_rdata2;
        default:                                  op2 = '0;
        endcase
    end

    // compares run through the subtractor as well
    assign sub_en   = i_bus.alu_ctrl.arith_sub | i_bus.alu_ctrl.res_cmp;
    assign op_b     = sub_en ? ~op2 : op2;
    assign sum      = {1'b0, op1} + {1'b0, op_b} + {32'b0, sub_en};
    assign overflow = (op1[31] ^ op2[31]) & (op1[31] ^ sum[31]);

    assign eq  = i_bus.alu_ctrl.cmp_inv ^ (op1 == op2);
    assign lts = i_bus.alu_ctrl.cmp_inv ^ (sum[31] ^ overflow);
    assign ltu = i_bus.alu_ctrl.cmp_inv ^ !sum[32];    // no carry out means borrow

    always_comb
    begin
        case (1'b1)
        i_bus.alu_ctrl.cmp_lts: cmp_res = lts;
        i_bus.alu_ctrl.cmp_ltu: cmp_res = ltu;
        default:                cmp_res = eq;
        endcase
    end

    always_comb
    begin
        case (1'b1)
        i_bus.alu_ctrl.bits_xor: bits_res = op1 ^ op2;
        i_bus.alu_ctrl.bits_or:  bits_res = op1 | op2;
        default:                 bits_res = op1 & op2;
        endcase
    end

    assign shl_res = op1 << op2[4:0];
    assign shr_res = $signed({i_bus.alu_ctrl.shift_arith & op1[31], op1}) >>> op2[4:0];

    always_comb
    begin
        case (1'b1)
        i_bus.alu_ctrl.res_cmp:   result = {31'b0, cmp_res};
        i_bus.alu_ctrl.res_bits:  result = bits_res;
        i_bus.alu_ctrl.res_shift: result = i_bus.funct3[2] ? shr_res[31:0] : shl_res;
        default:                  result = sum[31:0];
        endcase
    end

    // jalr takes rs1 plus imm from the adder
    assign target = i_bus.is_jalr ? {sum[31:1], 1'b0} : i_bus.pc + i_bus.imm;
    assign take   = i_bus.is_jal | i_bus.is_jalr | (i_bus.is_branch & cmp_res);

    always_ff @(posedge i_clk)
    begin
        if (i_exec_en)
        begin
            o_bus.result     <= result;
            o_bus.store_data <= i_rdata2;
            o_bus.pc_target  <= target;
            o_bus.pc_select  <= take;
            o_bus.rd         <= i_bus.rd;
            o_bus.reg_write  <= i_bus.reg_write;
            o_bus.res_src    <= i_bus.res_src;
            o_bus.funct3     <= i_bus.funct3;
            o_bus.is_load    <= i_bus.is_load;
            o_bus.is_store   <= i_bus.is_store;
            o_bus.pc         <= i_bus.pc;
        end
    end

endmodule

// ==== logic/rv_mem_access.sv ====
`timescale 1ns/1ps

module rv_mem_access
(
    input   logic                       i_clk,
    input   logic                       i_mem_ack,
    input   rv_ctrl_pkg::exec_bus_t     i_bus,
    input   rv_types_pkg::word_t        i_rdata,
    output  rv_types_pkg::word_t        o_wdata,
    output  rv_types_pkg::byte_sel_t    o_sel,
    output  rv_types_pkg::word_t        o_wb_data
);

    rv_types_pkg::word_t rdata_q;
    rv_types_pkg::word_t load_val;
    logic [7:0]          ld_byte;
    logic [15:0]         ld_half;
    logic [1:0]          offs;

    assign offs = i_bus.result[1:0];

    always_comb
    begin
        case (i_bus.funct3[1:0])
        2'b00:   o_wdata = {4{i_bus.store_data[7:0]}};
        2'b01:   o_wdata = {2{i_bus.store_data[15:0]}};
        default: o_wdata = i_bus.store_data;
        endcase
    end

    always_comb
    begin
        case (i_bus.funct3[1:0])
        2'b00:   o_sel = 4'b0001 << offs;
        2'b01:   o_sel = offs[1] ? 4'b1100 : 4'b0011;
        default: o_sel = 4'b1111;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_mem_ack)
            rdata_q <= i_rdata;
    end

    assign ld_byte = rdata_q[{offs, 3'b000} +: 8];
    assign ld_half = rdata_q[{offs[1], 4'b0000} +: 16];

    always_comb
    begin
        case (i_bus.funct3)
        3'b000:  load_val = {{24{ld_byte[7]}}, ld_byte};
        3'b001:  load_val = {{16{ld_half[15]}}, ld_half};
        3'b100:  load_val = {24'b0, ld_byte};
        3'b101:  load_val = {16'b0, ld_half};
        default: load_val = rdata_q;
        endcase
    end

    always_comb
    begin
        case (1'b1)
        i_bus.res_src.memory: o_wb_data = load_val;
        i_bus.res_src.pc_p4:  o_wb_data = i_bus.pc + 32'd4;   // link address
        i_bus.res_src.alu:    o_wb_data = i_bus.result;
        default:              o_wb_data = '0;
        endcase
    end

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
#(
    parameter rv_types_pkg::addr_t RESET_ADDR = 32'h0000_0000
)
(
    input   logic                       i_clk,
    input   logic                       i_reset_n,
    output  rv_types_pkg::addr_t        o_wb_adr,
    output  rv_types_pkg::word_t        o_wb_dat,
    input   rv_types_pkg::word_t        i_wb_dat,
    output  logic                       o_wb_we,
    output  rv_types_pkg::byte_sel_t    o_wb_sel,
    output  logic                       o_wb_stb,
    output  logic                       o_wb_cyc,
    input   logic                       i_wb_ack
);

    rv_ctrl_pkg::seq_state_t    state;
    rv_ctrl_pkg::seq_state_t    state_nxt;
    rv_ctrl_pkg::decode_bus_t   dbus;
    rv_ctrl_pkg::exec_bus_t     ebus;
    rv_types_pkg::word_t        instr;
    rv_types_pkg::addr_t        pc;
    rv_types_pkg::word_t        rdata1;
    rv_types_pkg::word_t        rdata2;
    rv_types_pkg::word_t        rdata1_q;
    rv_types_pkg::word_t        rdata2_q;
    rv_types_pkg::word_t        mem_wdata;
    rv_types_pkg::word_t        wb_value;
    rv_types_pkg::byte_sel_t    mem_sel;
    logic                       cyc_q;
    logic                       bus_ack;
    logic                       in_mem;

    assign bus_ack = i_wb_ack & cyc_q;
    assign in_mem  = (state == rv_ctrl_pkg::S_MEM);

    always_comb
    begin
        case (state)
        rv_ctrl_pkg::S_FETCH:  state_nxt = bus_ack ? rv_ctrl_pkg::S_DECODE : rv_ctrl_pkg::S_FETCH;
        rv_ctrl_pkg::S_DECODE: state_nxt = rv_ctrl_pkg::S_EXEC;
        rv_ctrl_pkg::S_EXEC:   state_nxt = rv_ctrl_pkg::S_MEM;
        rv_ctrl_pkg::S_MEM:
            if ((ebus.is_load | ebus.is_store) & !bus_ack)
                state_nxt = rv_ctrl_pkg::S_MEM;     // wait for the data ack
            else
                state_nxt = rv_ctrl_pkg::S_WB;
        default:               state_nxt = rv_ctrl_pkg::S_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state <= rv_ctrl_pkg::S_FETCH;
            cyc_q <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            cyc_q <= (state_nxt == rv_ctrl_pkg::S_FETCH) |
                     ((state_nxt == rv_ctrl_pkg::S_MEM) & (dbus.is_load | dbus.is_store));
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state == rv_ctrl_pkg::S_DECODE)
        begin
            rdata1_q <= rdata1;
            rdata2_q <= rdata2;
        end
    end

    assign o_wb_cyc = cyc_q;
    assign o_wb_stb = cyc_q;
    assign o_wb_adr = in_mem ? ebus.result : pc;
    assign o_wb_dat = mem_wdata;
    assign o_wb_we  = in_mem & ebus.is_store;
    assign o_wb_sel = in_mem ? mem_sel : 4'b1111;

    rv_fetch
    #(
        .RESET_ADDR     (RESET_ADDR)
    )
    rv_fetch_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_fetch_ack    (bus_ack & (state == rv_ctrl_pkg::S_FETCH)),
        .i_instr        (i_wb_dat),
        .i_pc_load      (state == rv_ctrl_pkg::S_WB),
        .i_pc_select    (ebus.pc_select),
        .i_pc_target    (ebus.pc_target),
        .o_pc           (pc),
        .o_instr        (instr)
    );

    rv_decode rv_decode_inst
    (
        .i_instr        (instr),
        .i_pc           (pc),
        .o_bus          (dbus)
    );

    rv_regs rv_regs_inst
    (
        .i_clk          (i_clk),
        .i_rs1          (dbus.rs1),
        .i_rs2          (dbus.rs2),
        .i_rd           (ebus.rd),
        .i_write        ((state == rv_ctrl_pkg::S_WB) & ebus.reg_write),
        .i_data         (wb_value),
        .o_data1        (rdata1),
        .o_data2        (rdata2)
    );

    rv_execute rv_execute_inst
    (
        .i_clk          (i_clk),
        .i_exec_en      (state == rv_ctrl_pkg::S_EXEC),
        .i_bus          (dbus),
        .i_rdata1       (rdata1_q),
        .i_rdata2       (rdata2_q),
        .o_bus          (ebus)
    );

    rv_mem_access rv_mem_access_inst
    (
        .i_clk          (i_clk),
        .i_mem_ack      (bus_ack & in_mem),
        .i_bus          (ebus),
        .i_rdata        (i_wb_dat),
        .o_wdata        (mem_wdata),
        .o_sel          (mem_sel),
        .o_wb_data      (wb_value)
    );

endmodule

// ==== bench/rv_core_assertions.sv ====
`timescale 1ns/1ps

module rv_core_assertions
(
    input   logic                       i_clk,
    input   logic                       i_reset_n,
    input   logic                       i_wb_cyc,
    input   logic                       i_wb_stb,
    input   logic                       i_wb_we,
    input   logic                       i_wb_ack,
    input   rv_types_pkg::addr_t        i_wb_adr,
    input   rv_types_pkg::word_t        i_wb_dat,
    input   rv_types_pkg::byte_sel_t    i_wb_sel
);

    // a write strobe comes from the sequencer state, the request from the bus register
    we_needs_request: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_wb_we |-> (i_wb_cyc && i_wb_stb))
        else $error("wishbone we is high outside a bus request");

    // a request that is not acked must stay unchanged into the next cycle
    request_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_wb_stb && !i_wb_ack) |=> (i_wb_stb && $stable(i_wb_adr) && $stable(i_wb_we) &&
                                     $stable(i_wb_sel) && $stable(i_wb_dat)))
        else $error("wishbone request changed or dropped before ack");

    idle_in_reset: assert property (@(posedge i_clk)
        !i_reset_n |=> !i_wb_cyc)
        else $error("wishbone cyc is high during reset");

endmodule

bind rv_core rv_core_assertions rv_core_assertions_inst
(
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_wb_cyc       (o_wb_cyc),
    .i_wb_stb       (o_wb_stb),
    .i_wb_we        (o_wb_we),
    .i_wb_ack       (i_wb_ack),
    .i_wb_adr       (o_wb_adr),
    .i_wb_dat       (o_wb_dat),
    .i_wb_sel       (o_wb_sel)
);

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

    localparam rv_types_pkg::addr_t DONE_ADDR = 32'h0000_0400;   // outside the modelled memory
    localparam int MAX_STORES       = 64;
    localparam int CYCLES_PER_INSTR = 14;

    logic                       clk = 1'b0;
    logic                       reset_n = 1'b0;
    logic                       ack = 1'b0;
    rv_types_pkg::word_t        rdata = '0;
    rv_types_pkg::addr_t        wb_adr;
    rv_types_pkg::word_t        wb_dat;
    rv_types_pkg::byte_sel_t    wb_sel;
    logic                       wb_we;
    logic                       wb_stb;
    logic                       wb_cyc;

    rv_types_pkg::word_t        mem [0:255];
    rv_types_pkg::addr_t        exp_adr [0:MAX_STORES-1];
    rv_types_pkg::word_t        exp_dat [0:MAX_STORES-1];
    rv_types_pkg::byte_sel_t    exp_sel [0:MAX_STORES-1];
    logic [8*16-1:0]            exp_name [0:MAX_STORES-1];
    int                         n_prog = 0;
    int                         n_exp = 0;
    int                         exp_idx = 0;
    int                         errors = 0;
    int                         cycles = 0;
    int                         cycle_limit;
    logic                       done = 1'b0;
    logic                       busy = 1'b0;
    logic [1:0]                 wait_left = '0;
    logic [31:0]                lfsr = 32'h9f990a37;

    rv_core #(.RESET_ADDR(32'h0000_0000)) rv_core_inst
    (
        .i_clk          (clk),
        .i_reset_n      (reset_n),
        .o_wb_adr       (wb_adr),
        .o_wb_dat       (wb_dat),
        .i_wb_dat       (rdata),
        .o_wb_we        (wb_we),
        .o_wb_sel       (wb_sel),
        .o_wb_stb       (wb_stb),
        .o_wb_cyc       (wb_cyc),
        .i_wb_ack       (ack)
    );

    always
    begin
        #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // skips comment and blank lines
    task automatic next_data_line(input int fd, output string s);
        int n;
        s = "";
        while (!$feof(fd))
        begin
            n = $fgets(s, fd);
            if (n > 1 && s.getc(0) != 8'h23)
                return;
        end
        s = "";
    endtask

    task automatic load_stimulus();
        int    fd;
        int    i;
        int    n;
        string s;
        for (i = 0; i < 256; i++)
            mem[i] = '0;
        fd = $fopen("bench/rv_core_stim.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open the stimulus file bench/rv_core_stim.txt");
            return;
        end
        next_data_line(fd, s);
        n = $sscanf(s, "%h", n_prog);
        for (i = 0; i < n_prog; i++)
        begin
            next_data_line(fd, s);
            n = $sscanf(s, "%h", mem[i]);
        end
        next_data_line(fd, s);
        n = $sscanf(s, "%h", n_exp);
        for (i = 0; i < n_exp; i++)
        begin
            next_data_line(fd, s);
            n = $sscanf(s, "%h %h %h %s", exp_adr[i], exp_dat[i], exp_sel[i], exp_name[i]);
        end
        $fclose(fd);
    endtask

    task automatic check_store();
        int b;
        if (wb_adr == DONE_ADDR)
        begin
            done = 1'b1;
            return;
        end
        assert (exp_idx < n_exp)
        else
        begin
            errors++;
            $display("store to %h with data %h came after all expected stores", wb_adr, wb_dat);
        end
        if (exp_idx < n_exp)
        begin
            assert (wb_adr == exp_adr[exp_idx] && wb_dat == exp_dat[exp_idx] &&
                    wb_sel == exp_sel[exp_idx])
            else
            begin
                errors++;
                $display("** Error %0s: expected adr %h dat %h sel %h, actual adr %h dat %h sel %h",
                         exp_name[exp_idx], exp_adr[exp_idx], exp_dat[exp_idx], exp_sel[exp_idx],
                         wb_adr, wb_dat, wb_sel);
            end
            exp_idx++;
        end
        for (b = 0; b < 4; b++)
            if (wb_sel[b])
                mem[wb_adr[9:2]][8*b +: 8] = wb_dat[8*b +: 8];
    endtask

    // wishbone slave with 0 to 3 wait cycles per access
    always @(posedge clk)
    begin
        #1;
        if (ack)
            ack = 1'b0;
        else if (wb_cyc && wb_stb)
        begin
            if (!busy)
            begin
                busy         = 1'b1;
                wait_left[0] = lfsr[0];
                lfsr         = lfsr_step(lfsr);
                wait_left[1] = lfsr[0];
                lfsr         = lfsr_step(lfsr);
            end
            if (wait_left == 2'd0)
            begin
                busy = 1'b0;
                if (wb_we)
                    check_store();
                else
                    rdata = mem[wb_adr[9:2]];
                ack = 1'b1;
            end
            else
                wait_left = wait_left - 2'd1;
        end
    end

    initial
    begin
        load_stimulus();
        cycle_limit = n_prog * 4 * CYCLES_PER_INSTR;
        repeat (5) @(posedge clk);
        #1 reset_n = 1'b1;
        while (!done && cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        assert (done)
        else
        begin
            errors++;
            $display("timeout: the program did not reach its done store in %0d cycles", cycles);
        end
        assert (exp_idx == n_exp)
        else
        begin
            errors++;
            $display("only %0d of %0d expected stores were seen", exp_idx, n_exp);
        end
        $display("errors: %0d, stores checked: %0d of %0d", errors, exp_idx, n_exp);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/rv_types_pkg.sv
logic/rv_ctrl_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regs.sv
logic/rv_execute.sv
logic/rv_mem_access.sv
logic/rv_core.sv
bench/rv_core_assertions.sv
bench/rv_core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb -f vlog.f -o Vrv_core_tb
	./obj_dir/Vrv_core_tb > sim.log 2>&1; rc=$$?; cat sim.log; \
	if [ $$rc -ne 0 ] || grep -q "Finished with errors" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== bench/rv_core_stim.txt ====
# program: word count, then one instruction word per line, all hex
# stores: count, then address data sel name per line, all hex except the name
4d  # program words
00500093  # addi x1, x0, 5
ffd00113  # addi x2, x0, -3
20000513  # addi x10, x0, 0x200
002081b3  # add x3, x1, x2
00352023  # sw x3, 0(x10)
40110233  # sub x4, x2, x1
00452223  # sw x4, 4(x10)
40125293  # srai x5, x4, 1
00552423  # sw x5, 8(x10)
01c25313  # srli x6, x4, 28
00652623  # sw x6, 12(x10)
001123b3  # slt x7, x2, x1
00113433  # sltu x8, x2, x1
001394b3  # sll x9, x7, x1
0084e4b3  # or x9, x9, x8
00952823  # sw x9, 16(x10)
0020c5b3  # xor x11, x1, x2
0065f633  # and x12, x11, x6
00c52a23  # sw x12, 20(x10)
02150023  # sb x1, 0x20(x10)
021500a3  # sb x1, 0x21(x10)
02150123  # sb x1, 0x22(x10)
021501a3  # sb x1, 0x23(x10)
02251223  # sh x2, 0x24(x10)
02251323  # sh x2, 0x26(x10)
00550783  # lb x15, 5(x10)
02f52823  # sw x15, 0x30(x10)
00454783  # lbu x15, 4(x10)
02f52a23  # sw x15, 0x34(x10)
02651783  # lh x15, 0x26(x10)
02f52c23  # sw x15, 0x38(x10)
02455783  # lhu x15, 0x24(x10)
02f52e23  # sw x15, 0x3c(x10)
00c52783  # lw x15, 12(x10)
04f52023  # sw x15, 0x40(x10)
00000713  # addi x14, x0, 0
00108463  # beq x1, x1, +8 taken
00176713  # ori x14, x14, 0x001
00208463  # beq x1, x2, +8 not taken
00276713  # ori x14, x14, 0x002
00209463  # bne x1, x2, +8 taken
00476713  # ori x14, x14, 0x004
00109463  # bne x1, x1, +8 not taken
00876713  # ori x14, x14, 0x008
00114463  # blt x2, x1, +8 taken
01076713  # ori x14, x14, 0x010
0020c463  # blt x1, x2, +8 not taken
02076713  # ori x14, x14, 0x020
0020d463  # bge x1, x2, +8 taken
04076713  # ori x14, x14, 0x040
00115463  # bge x2, x1, +8 not taken
08076713  # ori x14, x14, 0x080
0020e463  # bltu x1, x2, +8 taken
10076713  # ori x14, x14, 0x100
00116463  # bltu x2, x1, +8 not taken
20076713  # ori x14, x14, 0x200
00117463  # bgeu x2, x1, +8 taken
40076713  # ori x14, x14, 0x400
0020f463  # bgeu x1, x2, +8 not taken
80076713  # ori x14, x14, -0x800
04e52223  # sw x14, 0x44(x10)
0080086f  # jal x16, +8
00000813  # addi x16, x0, 0 skipped
00000897  # auipc x17, 0
01088967  # jalr x18, 16(x17)
00000913  # addi x18, x0, 0 skipped
00000913  # addi x18, x0, 0 skipped
05052423  # sw x16, 0x48(x10)
05252623  # sw x18, 0x4c(x10)
123459b7  # lui x19, 0x12345
00001a17  # auipc x20, 1
00700013  # addi x0, x0, 7
05352823  # sw x19, 0x50(x10)
05452a23  # sw x20, 0x54(x10)
04052c23  # sw x0, 0x58(x10)
40002023  # sw x0, 0x400(x0) done
0000006f  # jal x0, 0
17  # expected stores
00000200 00000002 f add
00000204 fffffff8 f sub
00000208 fffffffc f srai
0000020c 0000000f f srli
00000210 00000020 f slt_sltu_sll_or
00000214 00000008 f xor_and
00000220 05050505 1 sb_offset0
00000221 05050505 2 sb_offset1
00000222 05050505 4 sb_offset2
00000223 05050505 8 sb_offset3
00000224 fffdfffd 3 sh_offset0
00000226 fffdfffd c sh_offset2
00000230 ffffffff f lb
00000234 000000f8 f lbu
00000238 fffffffd f lh
0000023c 0000fffd f lhu
00000240 0000000f f lw
00000244 fffffaaa f branches
00000248 000000f8 f jal_link
0000024c 00000104 f jalr_link
00000250 12345000 f lui
00000254 00001118 f auipc
00000258 00000000 f x0_zero
